//--- include/inst_defs.svh
`ifndef INST_DEFS_SVH
`define INST_DEFS_SVH

// Instruction field ranges
`define OP_RANGE       6:0
`define FUNCT_3_RANGE  14:12
`define FUNCT_7_RANGE  31:25
`define FUNCT_7_ALT    30          // Selects SUB and SRA

// Major opcodes
`define OP_IMM    7'b0010011
`define OP_R3     7'b0110011
`define OP_LD     7'b0000011
`define OP_ST     7'b0100011
`define OP_BR     7'b1100011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

// ALU funct3
`define ADD_SUB   3'b000
`define SLL       3'b001
`define SLT       3'b010
`define SLTU      3'b011
`define XOR       3'b100
`define SRL_SRA   3'b101
`define OR        3'b110
`define AND       3'b111

// Branch funct3
`define BEQ       3'b000
`define BNE       3'b001
`define BLT       3'b100
`define BGE       3'b101
`define BLTU      3'b110
`define BGEU      3'b111

`endif

//--- verilog/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;     // Register and memory data
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                   // LUI passes the immediate through
    } alu_op_t;

    // Writeback source, same encoding as reg_write_ctrl
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_PC4  = 2'd1,
        WB_LOAD = 2'd2
    } wb_sel_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        MEM_WAIT
    } seq_state_t;

endpackage

//--- verilog/control_unit.sv
`include "inst_defs.svh"

module control_unit (
    input  rv_pkg::word_t    instr,
    output logic             registerfile_write_enable,
    output logic             pc_rs1_sel,      // 1 selects PC as ALU operand A
    output logic             imm_rs2_sel,     // 1 selects immediate as operand B
    output logic             jump_branch_sel, // Unconditional jump
    output logic             branch,          // Conditional branch, needs ALU condition
    output logic             mem_write_enable,
    output logic             mem_read,
    output rv_pkg::wb_sel_t  reg_write_ctrl,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::word_t    imm,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd
);

    rv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::alu_op_t alu_func;
    logic            alt;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];
    assign alt = instr[`FUNCT_7_ALT];

    // Sign-extended immediates for each format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU operation from funct3, SUB only exists for R-type
    always_comb begin
        case (instr[`FUNCT_3_RANGE])
            `ADD_SUB: begin
                if (alt && instr[`OP_RANGE] == `OP_R3) begin
                    alu_func = rv_pkg::ALU_SUB;
                end else begin
                    alu_func = rv_pkg::ALU_ADD;
                end
            end
            `SLL:     alu_func = rv_pkg::ALU_SLL;
            `SLT:     alu_func = rv_pkg::ALU_SLT;
            `SLTU:    alu_func = rv_pkg::ALU_SLTU;
            `XOR:     alu_func = rv_pkg::ALU_XOR;
            `SRL_SRA: alu_func = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            `OR:      alu_func = rv_pkg::ALU_OR;
            default:  alu_func = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // Defaults, then per-opcode overrides
        registerfile_write_enable = 1'b0;
        pc_rs1_sel       = 1'b0;
        imm_rs2_sel      = 1'b0;
        jump_branch_sel  = 1'b0;
        branch           = 1'b0;
        mem_write_enable = 1'b0;
        mem_read         = 1'b0;
        reg_write_ctrl   = rv_pkg::WB_ALU;
        alu_op           = rv_pkg::ALU_ADD;
        imm              = imm_i;

        case (instr[`OP_RANGE])
            `OP_IMM: begin
                registerfile_write_enable = 1'b1;
                imm_rs2_sel = 1'b1;
                alu_op      = alu_func;
            end
            `OP_R3: begin
                registerfile_write_enable = 1'b1;
                alu_op = alu_func;
            end
            `OP_LD: begin
                registerfile_write_enable = 1'b1;
                imm_rs2_sel    = 1'b1;
                mem_read       = 1'b1;
                reg_write_ctrl = rv_pkg::WB_LOAD;
            end
            `OP_ST: begin
                imm_rs2_sel      = 1'b1;
                mem_write_enable = 1'b1;
                imm              = imm_s;
            end
            `OP_BR: begin
                branch = 1'b1;           // rs1 vs rs2 compare
                imm    = imm_b;
            end
            `OP_LUI: begin
                registerfile_write_enable = 1'b1;
                imm_rs2_sel = 1'b1;
                alu_op      = rv_pkg::ALU_PASS_B;
                imm         = imm_u;
            end
            `OP_AUIPC: begin
                registerfile_write_enable = 1'b1;
                pc_rs1_sel  = 1'b1;
                imm_rs2_sel = 1'b1;
                imm         = imm_u;
            end
            `OP_JAL: begin
                registerfile_write_enable = 1'b1;
                pc_rs1_sel      = 1'b1;  // Target is PC + imm
                imm_rs2_sel     = 1'b1;
                jump_branch_sel = 1'b1;
                reg_write_ctrl  = rv_pkg::WB_PC4;
                imm             = imm_j;
            end
            `OP_JALR: begin
                registerfile_write_enable = 1'b1;
                imm_rs2_sel     = 1'b1;  // Target is rs1 + imm
                jump_branch_sel = 1'b1;
                reg_write_ctrl  = rv_pkg::WB_PC4;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/alu.sv
`include "inst_defs.svh"

module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  logic [2:0]      funct3,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = $signed(a) < $signed(b);
    assign unsigned_lt = a < b;

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << b[4:0];
            rv_pkg::ALU_SLT:  result = {31'd0, signed_lt};
            rv_pkg::ALU_SLTU: result = {31'd0, unsigned_lt};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> b[4:0];
            rv_pkg::ALU_SRA:  result = $signed(a) >>> b[4:0];
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = b;          // Pass B
        endcase
    end

    // Branch condition, only looked at for conditional branches
    always_comb begin
        case (funct3)
            `BEQ:    branch_taken = (a == b);
            `BNE:    branch_taken = (a != b);
            `BLT:    branch_taken = signed_lt;
            `BGE:    branch_taken = !signed_lt;
            `BLTU:   branch_taken = unsigned_lt;
            `BGEU:   branch_taken = !unsigned_lt;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/regfile.sv
module regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];   // Asynchronous reads
    assign rdata2 = regs[raddr2];

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fetch_start,
    input  logic          ir_load,
    input  logic          pc_update,
    input  logic          take_target,
    input  rv_pkg::addr_t target,
    input  rv_pkg::word_t fetch_rdata,
    output logic          fetch_req,
    output rv_pkg::addr_t fetch_addr,
    output rv_pkg::addr_t pc,
    output rv_pkg::addr_t pc_plus4,
    output rv_pkg::word_t instr
);

    assign pc_plus4   = pc + 32'd4;
    assign fetch_req  = fetch_start;
    assign fetch_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= take_target ? target : pc_plus4;   // Jump or taken branch
        end
    end

    // Instruction register, loaded the cycle after the fetch request
    always_ff @(posedge clk) begin
        if (ir_load) begin
            instr <= fetch_rdata;
        end
    end

endmodule

//--- verilog/core_sequencer.sv
module core_sequencer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mem_read,
    input  logic          mem_write_enable,
    input  logic          registerfile_write_enable,
    input  rv_pkg::addr_t data_addr_in,
    input  rv_pkg::word_t store_data,
    output logic          fetch_start,
    output logic          ir_load,
    output logic          pc_update,
    output logic          rf_we,
    output logic          load_done,
    output logic          data_req,
    output logic          data_we,
    output rv_pkg::addr_t data_addr,
    output rv_pkg::word_t data_wdata
);

    rv_pkg::seq_state_t state, state_next;
    logic               is_mem;

    assign is_mem = mem_read | mem_write_enable;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            rv_pkg::FETCH:  state_next = rv_pkg::DECODE;
            rv_pkg::DECODE: state_next = rv_pkg::EXEC;
            rv_pkg::EXEC:   state_next = is_mem ? rv_pkg::MEM : rv_pkg::FETCH;
            rv_pkg::MEM:    state_next = mem_read ? rv_pkg::MEM_WAIT : rv_pkg::FETCH;
            default:        state_next = rv_pkg::FETCH;
        endcase
    end

    assign fetch_start = (state == rv_pkg::FETCH);
    assign ir_load     = (state == rv_pkg::DECODE);   // Read data back from memory
    assign load_done   = (state == rv_pkg::MEM_WAIT);

    // Last step of each instruction retires it
    assign pc_update = (state == rv_pkg::EXEC && !is_mem)
                     | (state == rv_pkg::MEM && !mem_read)
                     | load_done;

    assign rf_we = registerfile_write_enable
                 & ((state == rv_pkg::EXEC && !is_mem) | load_done);

    // Data side of the memory port, quiet outside MEM
    assign data_req   = (state == rv_pkg::MEM);
    assign data_we    = data_req & mem_write_enable;
    assign data_addr  = data_req ? data_addr_in : '0;
    assign data_wdata = data_we ? store_data : '0;

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fetch_req,
    input  rv_pkg::addr_t fetch_addr,
    input  logic          data_req,
    input  logic          data_we,
    input  rv_pkg::addr_t data_addr,
    input  rv_pkg::word_t data_wdata,
    input  rv_pkg::word_t mem_rdata,
    output rv_pkg::word_t fetch_rdata,
    output rv_pkg::word_t data_rdata,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::addr_t mem_addr,
    output rv_pkg::word_t mem_wdata
);

    logic data_owner;   // Last read was issued by the data side

    // Data side wins when both ask
    assign mem_req   = fetch_req | data_req;
    assign mem_we    = data_req & data_we;
    assign mem_addr  = data_req ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_owner <= 1'b0;
        end else if (mem_req) begin
            data_owner <= data_req;
        end
    end

    // Read data arrives one cycle after the request
    assign fetch_rdata = data_owner ? '0 : mem_rdata;
    assign data_rdata  = data_owner ? mem_rdata : '0;

endmodule

//--- verilog/rv_core.sv
module rv_core #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t mem_rdata,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::addr_t mem_addr,
    output rv_pkg::word_t mem_wdata
);

    rv_pkg::addr_t    pc, pc_plus4, target, fetch_addr, data_addr;
    rv_pkg::word_t    instr, imm, rdata1, rdata2, alu_a, alu_b, alu_result, wb_data;
    rv_pkg::word_t    fetch_rdata, data_rdata, data_wdata;
    rv_pkg::reg_idx_t rs1, rs2, rd;
    rv_pkg::alu_op_t  alu_op;
    rv_pkg::wb_sel_t  reg_write_ctrl;
    logic registerfile_write_enable, pc_rs1_sel, imm_rs2_sel, jump_branch_sel, branch;
    logic mem_write_enable, mem_read, branch_taken, take_target;
    logic fetch_start, ir_load, pc_update, rf_we, load_done;
    logic fetch_req, data_req, data_we;

    // Operand and writeback muxes
    assign alu_a = pc_rs1_sel ? pc : rdata1;
    assign alu_b = imm_rs2_sel ? imm : rdata2;
    assign wb_data = (reg_write_ctrl == rv_pkg::WB_LOAD && load_done) ? data_rdata
                   : (reg_write_ctrl == rv_pkg::WB_PC4) ? pc_plus4 : alu_result;

    // Jumps use the ALU sum with bit 0 cleared, branches PC + imm
    assign target      = jump_branch_sel ? {alu_result[31:1], 1'b0} : pc + imm;
    assign take_target = jump_branch_sel | (branch & branch_taken);

    control_unit u_ctrl (.instr, .registerfile_write_enable, .pc_rs1_sel, .imm_rs2_sel,
        .jump_branch_sel, .branch, .mem_write_enable, .mem_read, .reg_write_ctrl,
        .alu_op, .imm, .rs1, .rs2, .rd);

    alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .funct3(instr[14:12]),
        .result(alu_result), .branch_taken);

    regfile u_rf (.clk, .rst_n, .we(rf_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
        .wdata(wb_data), .rdata1, .rdata2);

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (.clk, .rst_n, .fetch_start, .ir_load,
        .pc_update, .take_target, .target, .fetch_rdata, .fetch_req, .fetch_addr,
        .pc, .pc_plus4, .instr);

    core_sequencer u_seq (.clk, .rst_n, .mem_read, .mem_write_enable,
        .registerfile_write_enable, .data_addr_in(alu_result), .store_data(rdata2),
        .fetch_start, .ir_load, .pc_update, .rf_we, .load_done, .data_req, .data_we,
        .data_addr, .data_wdata);

    mem_arbiter u_arb (.clk, .rst_n, .fetch_req, .fetch_addr, .data_req, .data_we,
        .data_addr, .data_wdata, .mem_rdata, .fetch_rdata, .data_rdata, .mem_req,
        .mem_we, .mem_addr, .mem_wdata);

endmodule

//--- bench/mem_model.sv
module mem_model #(
    parameter int DEPTH = 256
) (
    input  logic          clk,
    input  logic          mem_req,
    input  logic          mem_we,
    input  rv_pkg::addr_t mem_addr,
    input  rv_pkg::word_t mem_wdata,
    output rv_pkg::word_t mem_rdata
);

    rv_pkg::word_t mem [DEPTH];
    int            store_count = 0;   // Number of writes seen

    initial mem_rdata = '0;

    // Background pattern built from the full byte address
    task automatic fill();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i[7:0]] = 32'hC0DE_0000 ^ (i << 2);
        end
    endtask

    task automatic load_word(input int idx, input rv_pkg::word_t w);
        mem[idx[7:0]] = w;
    endtask

    // One-cycle read latency, write when req and we are both high
    always @(posedge clk) begin
        if (mem_req) begin
            if (mem_we) begin
                mem[mem_addr[9:2]] <= mem_wdata;
                store_count <= store_count + 1;
            end else begin
                mem_rdata <= mem[mem_addr[9:2]];
            end
        end
    end

endmodule

//--- bench/tb_core.sv
`include "inst_defs.svh"

module tb_core;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          mem_req, mem_we;
    rv_pkg::addr_t mem_addr, end_pc;
    rv_pkg::word_t mem_wdata, mem_rdata;

    rv_pkg::word_t prog [256];        // Program table
    string         exp_name [64];     // Expected store table
    rv_pkg::addr_t exp_addr [64];
    rv_pkg::word_t exp_data [64];
    int n_prog = 0;
    int n_exp = 0;
    int value_errors = 0;
    int other_errors = 0;

    always #4 clk = ~clk;

    rv_core #(.RESET_PC('0)) DUT (.clk, .rst_n, .mem_rdata, .mem_req, .mem_we,
        .mem_addr, .mem_wdata);

    mem_model u_mem (.clk, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata);

    function automatic rv_pkg::word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd,
                                            logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic rv_pkg::word_t enc_r(int f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_R3};
    endfunction

    function automatic rv_pkg::word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_ST};
    endfunction

    function automatic rv_pkg::word_t enc_b(int imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], `OP_BR};
    endfunction

    function automatic rv_pkg::word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
    endfunction

    task automatic emit(input rv_pkg::word_t w);
        prog[n_prog[7:0]] = w;
        n_prog++;
    endtask

    // SW to the result area and record the value it must carry
    task automatic store_result(input int rs2, input string name, input rv_pkg::word_t value);
        emit(enc_s(4 * n_exp, rs2, 10));
        exp_name[n_exp[5:0]] = name;
        exp_addr[n_exp[5:0]] = 512 + 4 * n_exp;
        exp_data[n_exp[5:0]] = value;
        n_exp++;
    endtask

    // x22 keeps its marker when taken and gets +1 on fall-through
    task automatic branch_case(input string name, input logic [2:0] f3, input int rs1,
                               input int rs2, input int taken);
        int val;
        val = 16 + 2 * n_exp;
        emit(enc_i(val, 0, 0, 22, `OP_IMM));
        emit(enc_b(8, rs2, rs1, f3));
        emit(enc_i(1, 22, 0, 22, `OP_IMM));
        store_result(22, name, (taken != 0) ? val : val + 1);
    endtask

    task automatic check_addr(input string name, input rv_pkg::addr_t exp,
                              input rv_pkg::addr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic build_program();
        int p;
        emit(enc_i(512, 0, 0, 10, `OP_IMM));                 // x10 = result base
        emit(enc_i(-5, 0, 0, 1, `OP_IMM));
        emit(enc_i(3, 1, `SLT, 2, `OP_IMM));
        emit(enc_i('h0F0, 1, `XOR, 3, `OP_IMM));
        emit(enc_i(4, 1, `SLL, 4, `OP_IMM));
        emit(enc_i('h401, 1, `SRL_SRA, 5, `OP_IMM));         // SRAI by 1
        emit(enc_i(28, 1, `SRL_SRA, 6, `OP_IMM));
        emit({20'h12345, 5'd7, `OP_LUI});
        emit({20'h00001, 5'd8, `OP_AUIPC});                  // At address 32
        store_result(2, "slti", 32'h0000_0001);
        store_result(3, "xori", 32'hFFFF_FF0B);
        store_result(4, "slli", 32'hFFFF_FFB0);
        store_result(5, "srai", 32'hFFFF_FFFD);
        store_result(6, "srli", 32'h0000_000F);
        store_result(7, "lui", 32'h1234_5000);
        store_result(8, "auipc", 32'h0000_1020);
        emit(enc_i(7, 0, 0, 11, `OP_IMM));
        emit(enc_r(0, 11, 1, `ADD_SUB, 12));
        emit(enc_r('h20, 11, 1, `ADD_SUB, 13));
        emit(enc_r(0, 11, 11, `SLL, 14));
        emit(enc_r(0, 11, 1, `SLT, 15));
        emit(enc_r(0, 11, 1, `SLTU, 16));
        emit(enc_r(0, 11, 1, `XOR, 17));
        emit(enc_r(0, 11, 1, `SRL_SRA, 18));
        emit(enc_r('h20, 11, 1, `SRL_SRA, 19));
        emit(enc_r(0, 11, 1, `OR, 20));
        emit(enc_r(0, 11, 1, `AND, 21));
        store_result(12, "add", 32'h0000_0002);
        store_result(13, "sub", 32'hFFFF_FFF4);
        store_result(14, "sll", 32'h0000_0380);
        store_result(15, "slt", 32'h0000_0001);
        store_result(16, "sltu", 32'h0000_0000);
        store_result(17, "xor", 32'hFFFF_FFFC);
        store_result(18, "srl", 32'h01FF_FFFF);
        store_result(19, "sra", 32'hFFFF_FFFF);
        store_result(20, "or", 32'hFFFF_FFFF);
        store_result(21, "and", 32'h0000_0003);
        emit(enc_i(4, 10, 3'b010, 23, `OP_LD));              // Reload the xori word
        store_result(23, "lw_round_trip", 32'hFFFF_FF0B);
        branch_case("beq_taken", `BEQ, 11, 11, 1);
        branch_case("beq_not", `BEQ, 1, 11, 0);
        branch_case("bne_taken", `BNE, 1, 11, 1);
        branch_case("bne_not", `BNE, 11, 11, 0);
        branch_case("blt_taken", `BLT, 1, 11, 1);
        branch_case("blt_not", `BLT, 11, 1, 0);
        branch_case("bge_taken", `BGE, 11, 1, 1);
        branch_case("bge_not", `BGE, 1, 11, 0);
        branch_case("bltu_taken", `BLTU, 11, 1, 1);
        branch_case("bltu_not", `BLTU, 1, 11, 0);
        branch_case("bgeu_taken", `BGEU, 1, 11, 1);
        branch_case("bgeu_not", `BGEU, 11, 1, 0);
        emit(enc_i(55, 0, 0, 0, `OP_IMM));
        store_result(0, "x0_write", 32'h0);
        p = 4 * n_prog;
        emit(enc_j(8, 24));
        emit(enc_s('h3FC, 1, 0));                            // Skipped by the jump
        store_result(24, "jal_link", p + 4);
        p = 4 * n_prog;
        emit({20'h0, 5'd26, `OP_AUIPC});
        emit(enc_i(13, 26, 0, 27, `OP_JALR));                // Odd target whose bit 0 is dropped
        emit(enc_s('h3FC, 1, 0));
        store_result(27, "jalr_link", p + 8);
        end_pc = 4 * n_prog;
        emit(enc_j(0, 0));                                   // Self-loop
    endtask

    // No write may reach memory while reset is held
    always @(negedge clk) begin
        if (rst_n !== 1'b1 && mem_req === 1'b1 && mem_we === 1'b1) begin
            $display("Memory write seen while reset was asserted");
            other_errors++;
        end
    end

    initial begin
        int cycles;
        int limit;
        int idx;
        logic first;
        logic done;
        cycles = 0;
        idx = 0;
        first = 1'b1;
        done = 1'b0;
        rst_n = 1'b0;
        build_program();
        u_mem.fill();
        for (int i = 0; i < n_prog; i++) begin
            u_mem.load_word(i, prog[i[7:0]]);
        end
        limit = 5 * n_prog + 50;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (first) begin
                // The very first cycle out of reset must be a read
                if (mem_req !== 1'b1 || mem_we !== 1'b0) begin
                    $display("No fetch was issued in the first cycle after reset");
                    other_errors++;
                end
                check_addr("reset_fetch", '0, mem_addr);
                first = 1'b0;
            end
            if (mem_req) begin
                if (mem_we) begin
                    if (idx >= n_exp) begin
                        $display("Unexpected store to address %h", mem_addr);
                        other_errors++;
                    end else begin
                        check_addr(exp_name[idx[5:0]], exp_addr[idx[5:0]], mem_addr);
                        check_word(exp_name[idx[5:0]], exp_data[idx[5:0]], mem_wdata);
                    end
                    idx++;
                end else if (mem_addr == end_pc) begin
                    done = 1'b1;
                end
            end
        end
        if (!done) begin
            $display("Timeout: program did not reach its final loop in %0d cycles", limit);
            other_errors++;
        end
        if (idx < n_exp) begin
            $display("Missing stores: %0d of %0d seen", idx, n_exp);
            other_errors++;
        end
        if (u_mem.store_count != n_exp) begin
            $display("Memory took %0d writes where %0d were expected", u_mem.store_count, n_exp);
            other_errors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
verilog/rv_pkg.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/regfile.sv
verilog/fetch_unit.sv
verilog/core_sequencer.sv
verilog/mem_arbiter.sv
verilog/rv_core.sv
bench/mem_model.sv
bench/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
